// File: hdl/perf_pkg.sv
package perf_pkg;

	// one bus word, also the width of every counter
	typedef logic [31:0] rv32i_word;

	// number of event counters in the bank
	localparam int num_counters = 9;

	// one strobe per counter, bit i goes with selector i
	typedef logic [num_counters-1:0] perf_event_t;

	// byte offsets of the counters in the lowest page
	typedef enum logic [7:0] {
		icache_hit       = 8'h00,
		icache_miss      = 8'h04,
		dcache_hit       = 8'h08,
		dcache_miss      = 8'h0C,
		l2_hit           = 8'h10,
		l2_miss          = 8'h14,
		ewb_writes       = 8'h18,
		branch_total     = 8'h1C,
		branch_incorrect = 8'h20
	} perf_sel_t;

	// counter values as a whole, indexed like perf_event_t
	typedef rv32i_word rv32i_word_array_t [num_counters];

	// true when the low byte names one of the counters
	function automatic logic is_counter_sel(logic [7:0] offset);
		logic valid;
		case (perf_sel_t'(offset))
			icache_hit, icache_miss,
			dcache_hit, dcache_miss,
			l2_hit, l2_miss,
			ewb_writes,
			branch_total, branch_incorrect: valid = 1'b1;
			default: valid = 1'b0;
		endcase
		return valid;
	endfunction

endpackage : perf_pkg

// File: hdl/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
	import perf_pkg::*;

	// request side, held until resp
	rv32i_word addr;
	logic      read;
	logic      write;
	rv32i_word wdata;

	// response side, resp is a single-cycle pulse
	rv32i_word rdata;
	logic      resp;

	modport requester (
		output addr,
		output read,
		output write,
		output wdata,
		input  rdata,
		input  resp
	);

	modport responder (
		input  addr,
		input  read,
		input  write,
		input  wdata,
		output rdata,
		output resp
	);

endinterface : mem_bus_if

// File: hdl/perf_cnt_if.sv
`timescale 1ns/1ps

interface perf_cnt_if;
	import perf_pkg::*;

	// live counter values from the bank
	rv32i_word_array_t count;

	// clear strobes from the decoder, at most one high
	logic [num_counters-1:0] clear;

	modport decoder (
		input  count,
		output clear
	);

	modport bank (
		output count,
		input  clear
	);

endinterface : perf_cnt_if

// File: hdl/perf_counter_decode.sv
`timescale 1ns/1ps

module perf_counter_decode (
	input  perf_pkg::rv32i_word mem_addr,
	input  logic                mem_read,
	input  logic                mem_write,
	input  perf_pkg::rv32i_word mem_wdata,
	output perf_pkg::rv32i_word mem_rdata,
	output logic                mem_resp,
	mem_bus_if.requester        ram,
	perf_cnt_if.decoder         cnt
);
	import perf_pkg::*;

	localparam int idx_w = $clog2(num_counters);

	logic             addr_hit;
	logic             counter_req;
	logic [idx_w-1:0] cnt_idx;
	rv32i_word        cnt_rdata;

	// counters sit only in the first 256 bytes
	assign addr_hit = (mem_addr[31:8] == 24'h000000) & is_counter_sel(mem_addr[7:0]);

	// selectors are word offsets, so bits 5:2 give the index
	assign cnt_idx = mem_addr[idx_w+1:2];

	assign counter_req = (mem_read | mem_write) & addr_hit;

	// misses go through to the backing memory unchanged
	assign ram.addr  = mem_addr;
	assign ram.wdata = mem_wdata;
	assign ram.read  = mem_read & ~addr_hit;
	assign ram.write = mem_write & ~addr_hit;

	// counter select and clear strobes
	always_comb begin
		cnt_rdata = '0;
		cnt.clear = '0;
		for (int i = 0; i < num_counters; i++) begin
			if (cnt_idx == idx_w'(i)) begin
				cnt_rdata = cnt.count[i];
				// write data is ignored, any write clears
				cnt.clear[i] = mem_write & addr_hit;
			end
		end
	end

	// counter hits answer in the same cycle
	always_comb begin
		if (counter_req) begin
			mem_resp = 1'b1;
		end else begin
			mem_resp = ram.resp;
		end
	end

	always_comb begin
		if (mem_read & addr_hit) begin
			mem_rdata = cnt_rdata;
		end else begin
			mem_rdata = ram.rdata;
		end
	end

	// a memory response can never land on a counter access
	always_comb begin
		assert ((counter_req & ram.resp) !== 1'b1)
			else $error("ram response during counter access at %h", mem_addr);
	end

endmodule : perf_counter_decode

// File: hdl/perf_counter_bank.sv
`timescale 1ns/1ps

module perf_counter_bank (
	input  logic                  clk,
	input  logic                  rst,
	input  perf_pkg::perf_event_t events,
	perf_cnt_if.bank              cnt
);
	import perf_pkg::*;

	rv32i_word_array_t count_q;

	// reset, then clear, then event
	always_ff @(posedge clk) begin
		for (int i = 0; i < num_counters; i++) begin
			if (rst) begin
				count_q[i] <= '0;
			end else if (cnt.clear[i]) begin
				count_q[i] <= '0;
			end else if (events[i]) begin
				// wraps at 2^32
				count_q[i] <= count_q[i] + 32'd1;
			end
		end
	end

	assign cnt.count = count_q;

	// decoder addresses one counter per access
	assert property (@(posedge clk) disable iff (rst) $onehot0(cnt.clear))
		else $error("more than one counter clear: %b", cnt.clear);

endmodule : perf_counter_bank

// File: hdl/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
	parameter int ram_addr_w = 10
) (
	input  logic         clk,
	input  logic         rst,
	mem_bus_if.responder bus
);
	import perf_pkg::*;

	localparam int depth = 2 ** ram_addr_w;

	typedef logic [ram_addr_w-1:0] ram_idx_t;

	rv32i_word mem [depth];
	rv32i_word rdata_q;
	logic      resp_q;
	ram_idx_t  idx;
	logic      req;
	logic      accept;

	// word address, byte offset dropped
	assign idx = bus.addr[ram_addr_w+1:2];

	assign req = bus.read | bus.write;

	// a request held through resp is not taken twice
	assign accept = req & ~resp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_q <= 1'b0;
		end else begin
			resp_q <= accept;
		end
	end

	// storage and read data
	always_ff @(posedge clk) begin
		if (accept & bus.write) begin
			mem[idx] <= bus.wdata;
		end
		if (accept & bus.read) begin
			rdata_q <= mem[idx];
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.resp  = resp_q;

	// every resp answers a request that is still held
	assert property (@(posedge clk) disable iff (rst) bus.resp |-> req)
		else $error("ram resp without a held request");

	// read and write are never raised together
	assert property (@(posedge clk) disable iff (rst) !(bus.read && bus.write))
		else $error("ram read and write raised together");

endmodule : word_ram

// File: hdl/perf_mmio_top.sv
`timescale 1ns/1ps

module perf_mmio_top #(
	parameter int ram_addr_w = 10
) (
	input  logic                  clk,
	input  logic                  rst,

	// core data port
	input  perf_pkg::rv32i_word   mem_addr,
	input  logic                  mem_read,
	input  logic                  mem_write,
	input  perf_pkg::rv32i_word   mem_wdata,
	output perf_pkg::rv32i_word   mem_rdata,
	output logic                  mem_resp,

	// event strobes, one per counter
	input  perf_pkg::perf_event_t events
);

	// decoder to backing memory
	mem_bus_if ram_bus ();

	// decoder to counter bank
	perf_cnt_if cnt_bus ();

	// address decode, counter reads and clears
	perf_counter_decode i_perf_counter_decode (
		.mem_addr  (mem_addr),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_resp  (mem_resp),
		.ram       (ram_bus.requester),
		.cnt       (cnt_bus.decoder)
	);

	// the nine event counters
	perf_counter_bank i_perf_counter_bank (
		.clk    (clk),
		.rst    (rst),
		.events (events),
		.cnt    (cnt_bus.bank)
	);

	// everything outside the counter page
	word_ram #(
		.ram_addr_w (ram_addr_w)
	) i_word_ram (
		.clk (clk),
		.rst (rst),
		.bus (ram_bus.responder)
	);

endmodule : perf_mmio_top

// File: tests/perf_mmio_tb.sv
`timescale 1ns/1ps

module perf_mmio_tb;
	import perf_pkg::*;

	localparam string input_path = "tests/perf_mmio_input.txt";

	logic        clk = 1'b0;
	logic        rst;
	rv32i_word   mem_addr;
	logic        mem_read;
	logic        mem_write;
	rv32i_word   mem_wdata;
	rv32i_word   mem_rdata;
	logic        mem_resp;
	perf_event_t events;

	// parsed operations, one entry per non-comment line
	byte       op_q [$];
	rv32i_word a_q [$];
	rv32i_word b_q [$];
	int        ln_q [$];

	rv32i_word   model_cnt [num_counters];
	logic [15:0] lfsr_state = 16'd60515;
	logic        load_done = 1'b0;
	int          value_errors = 0;
	int          resp_errors = 0;
	int          other_errors = 0;

	perf_mmio_top #(
		.ram_addr_w (10)
	) i_perf_mmio_top (
		.clk       (clk),
		.rst       (rst),
		.mem_addr  (mem_addr),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_resp  (mem_resp),
		.events    (events)
	);

	always #5 clk = ~clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	// counters live at word offsets 0x00 to 0x20 of page zero
	function automatic logic is_counter_addr(input rv32i_word a);
		return (a[31:8] == 24'h0) && (a[1:0] == 2'b00) && (a[7:0] <= 8'h20);
	endfunction

	task automatic next_random_mask(output perf_event_t m);
		for (int i = 0; i < num_counters; i++) begin
			m[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_word(input string name, input rv32i_word exp, input rv32i_word act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_resp(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
			resp_errors++;
		end
	endtask

	// model of one clock edge, a clear wins over an event
	task automatic apply_edge(input perf_event_t ev, input int clr_idx);
		for (int i = 0; i < num_counters; i++) begin
			if (i == clr_idx) begin
				model_cnt[i] = '0;
			end else if (ev[i]) begin
				model_cnt[i] = model_cnt[i] + 32'd1;
			end
		end
	endtask

	task automatic load_input();
		int        fd;
		int        nf;
		int        line_no;
		byte       ch;
		string     line;
		string     rest;
		rv32i_word a;
		rv32i_word b;
		line_no = 0;
		fd = $fopen(input_path, "r");
		if (fd == 0) begin
			$display("could not open the input file %s", input_path);
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			line_no++;
			if (line.len() < 2) begin
				continue;
			end
			ch = line.getc(0);
			if (ch == "#") begin
				continue;
			end
			rest = line.substr(1, line.len() - 1);
			a = '0;
			b = '0;
			case (ch)
				"E": nf = ($sscanf(rest, "%h %d", a, b) == 2);
				"L": nf = ($sscanf(rest, "%d", a) == 1);
				"W", "R", "K": nf = ($sscanf(rest, "%h %h", a, b) == 2);
				"C": nf = ($sscanf(rest, "%h", a) == 1);
				default: nf = 0;
			endcase
			if (nf == 0) begin
				$display("input line %0d could not be parsed", line_no);
				other_errors++;
			end else begin
				op_q.push_back(ch);
				a_q.push_back(a);
				b_q.push_back(b);
				ln_q.push_back(line_no);
			end
		end
		$fclose(fd);
	endtask

	// one request, held until mem_resp, dropped in the cycle after
	task automatic run_access(input string name, input logic is_wr, input rv32i_word addr,
			input rv32i_word wdata, input perf_event_t ev, input logic is_cnt,
			output rv32i_word rdata);
		logic resp_now;
		int   waited;
		mem_addr  = addr;
		mem_wdata = wdata;
		mem_read  = ~is_wr;
		mem_write = is_wr;
		events    = ev;
		#4;
		resp_now = mem_resp;
		waited = 0;
		check_resp({name, " resp in request cycle"}, is_cnt, resp_now);
		if (!is_cnt && !resp_now) begin
			@(posedge clk);
			#1;
			events = '0;
			#4;
			resp_now = mem_resp;
			waited = 1;
			check_resp({name, " resp one cycle after request"}, 1'b1, resp_now);
		end
		while (!resp_now && waited < 8) begin
			@(posedge clk);
			#1;
			events = '0;
			#4;
			resp_now = mem_resp;
			waited++;
		end
		if (!resp_now) begin
			$display("%s got no mem_resp within 8 cycles", name);
			other_errors++;
		end
		rdata = mem_rdata;
		@(posedge clk);
		#1;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		events    = '0;
	endtask

	// watchdog, 20 cycles per operation plus reset
	initial begin
		int unsigned timeout_ns;
		wait (load_done);
		timeout_ns = (8 + 20 * op_q.size()) * 10;
		#(timeout_ns);
		$display("timeout after %0d ns, the test did not finish", timeout_ns);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rv32i_word   rd;
		rv32i_word   addr;
		perf_event_t m;
		perf_sel_t   sel;
		string       name;
		int          idx;
		int          ncyc;
		rst       = 1'b1;
		mem_addr  = '0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		mem_wdata = '0;
		events    = '0;
		for (int i = 0; i < num_counters; i++) begin
			model_cnt[i] = '0;
		end
		load_input();
		load_done = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int k = 0; k < op_q.size(); k++) begin
			addr = a_q[k];
			idx = int'(addr[7:2]);
			case (op_q[k])
				"E", "L": begin
					ncyc = (op_q[k] == "E") ? int'(b_q[k]) : int'(a_q[k]);
					for (int c = 0; c < ncyc; c++) begin
						if (op_q[k] == "E") begin
							m = a_q[k][num_counters-1:0];
						end else begin
							next_random_mask(m);
						end
						events = m;
						@(posedge clk);
						#1;
						apply_edge(m, -1);
					end
					events = '0;
				end
				"W": begin
					name = $sformatf("line %0d write %h", ln_q[k], addr);
					run_access(name, 1'b1, addr, b_q[k], '0, is_counter_addr(addr), rd);
					if (is_counter_addr(addr)) begin
						apply_edge('0, idx);
					end
				end
				"K": begin
					name = $sformatf("line %0d clear %h with events", ln_q[k], addr);
					if (!is_counter_addr(addr)) begin
						$display("input line %0d names no counter address", ln_q[k]);
						other_errors++;
					end else begin
						m = b_q[k][num_counters-1:0];
						run_access(name, 1'b1, addr, '0, m, 1'b1, rd);
						apply_edge(m, idx);
					end
				end
				"R": begin
					name = $sformatf("line %0d read %h", ln_q[k], addr);
					run_access(name, 1'b0, addr, '0, '0, 1'b0, rd);
					check_word(name, b_q[k], rd);
				end
				default: begin
					sel = perf_sel_t'(addr[7:0]);
					addr = {24'h0, addr[7:0]};
					name = $sformatf("line %0d counter %s", ln_q[k], sel.name());
					run_access(name, 1'b0, addr, '0, '0, 1'b1, rd);
					check_word(name, model_cnt[idx], rd);
				end
			endcase
		end

		repeat (2) @(posedge clk);
		$display("value errors: %0d, resp errors: %0d, other errors: %0d",
			value_errors, resp_errors, other_errors);
		if (value_errors + resp_errors + other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : perf_mmio_tb

// File: tests/perf_mmio_input.txt
# E mask cycles | L cycles | W addr data | R addr expected | C selector | K selector event_mask
# all values hex except the cycle counts, which are decimal
C 00
C 04
C 08
C 0c
C 10
C 14
C 18
C 1c
C 20
E 1ff 5
E 0a5 3
L 12
W 24 deadbeef
W 100 cafef00d
W 80000040 12345678
C 00
C 04
C 08
C 0c
C 10
C 14
C 18
C 1c
C 20
W 1c 0
K 08 1ff
C 1c
C 08
C 0c
W 04 ffffffff
R 24 deadbeef
R 100 cafef00d
R 80000040 12345678
L 10
C 04
C 20

// File: perf_mmio_top.f
hdl/perf_pkg.sv
hdl/mem_bus_if.sv
hdl/perf_cnt_if.sv
hdl/perf_counter_decode.sv
hdl/perf_counter_bank.sv
hdl/word_ram.sv
hdl/perf_mmio_top.sv
tests/perf_mmio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the perf_mmio testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module perf_mmio_tb \
	--Mdir obj_dir -o perf_mmio_sim \
	-f perf_mmio_top.f

./obj_dir/perf_mmio_sim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
	echo "run_sim: PASS"
	exit 0
else
	echo "run_sim: FAIL"
	exit 1
fi
